/* verilog.f */
+incdir+verilog
verilog/gemm_pkg.sv
verilog/cmd_decode.sv
verilog/mac_lanes.sv
verilog/result_stage.sv
verilog/gemm_core_top.sv
sim/tb_gemm_core.sv

/* Makefile */
# Verilator build and run for the GEMM core testbench

TOP := tb_gemm_core
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f verilog.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "No result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_gemm_core.sv */
// GEMM core testbench
`timescale 1ns/1ps
`include "gemm_defs.svh"

module tb_gemm_core;
	import gemm_pkg::*;

	localparam int N_CMD   = 120;
	localparam int N_PLAIN = 60;
	localparam int LIMIT   = N_CMD * 200 + 1000;  // Watchdog in cycles

	logic      axi_aclk;
	logic      rst_n;
	logic      cmd_fifo_empty;
	cmd_word_t xocc_cmd_in;
	logic      cmd_fifo_rd_en;
	logic      opd_fifo_empty;
	beat_t     opd_in;
	logic      opd_fifo_rd_en;
	logic      rsp_fifo_full;
	logic      rsp_fifo_wr_en;
	cmd_word_t xocc_rsp_out;
	logic      result_valid;
	acc_vec_t  result_data;

	// FIFO contents and expected traffic
	cmd_word_t cmd_q[$];
	beat_t     opd_q[$];
	cmd_word_t exp_rsp_q[$];
	acc_vec_t  exp_res_q[$];
	int        exp_cyc_q[$];     // Cycle where each result_valid is due
	int        beats_of[N_CMD];  // Operand beats per command, bias included

	int cyc;
	int cmd_idx;
	int beats_left;
	int rsp_seen;
	int n_checks;
	int n_errors;

	gemm_core_top dut0 (
		.axi_aclk       (axi_aclk),
		.rst_n          (rst_n),
		.cmd_fifo_empty (cmd_fifo_empty),
		.xocc_cmd_in    (xocc_cmd_in),
		.cmd_fifo_rd_en (cmd_fifo_rd_en),
		.opd_fifo_empty (opd_fifo_empty),
		.opd_in         (opd_in),
		.opd_fifo_rd_en (opd_fifo_rd_en),
		.rsp_fifo_full  (rsp_fifo_full),
		.rsp_fifo_wr_en (rsp_fifo_wr_en),
		.xocc_rsp_out   (xocc_rsp_out),
		.result_valid   (result_valid),
		.result_data    (result_data)
	);

	initial begin
		axi_aclk = 1'b0;
		forever #4 axi_aclk = ~axi_aclk;
	end

	task automatic report_error(input string msg);
		n_errors++;
		$display("ERROR at cycle %0d: %s", cyc, msg);
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		n_checks++;
		assert (got === exp) else begin
			n_errors++;
			$display("CHECK FAILED %s: got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic end_run();
		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	// Commands, operand beats and the reference results
	task automatic build_stimulus();
		int                    n_plain;
		logic                  bad;
		logic                  bias;
		logic                  relu;
		blk_t                  blk;
		logic [`GEMM_OP_W-1:0] op;
		tag_t                  tag;
		beat_t                 b;
		acc_vec_t              acc;
		cmd_word_t             w;
		cmd_word_t             rsp;
		n_plain = 0;
		for (int i = 0; i < N_CMD; i++) begin
			tag  = tag_t'($urandom);
			op   = `GEMM_OP_MAC;
			blk  = blk_t'($urandom_range(63, 1));
			bias = 1'b0;
			relu = 1'b0;
			bad  = (i % 8 == 5);
			if (bad) begin
				bias = 1'($urandom_range(1));
				relu = 1'($urandom_range(1));
				if (i % 16 == 5) begin
					blk = '0;  // Empty block
				end else begin
					op = 4'(($urandom_range(14) + 2) % 16);  // Any opcode but MAC
				end
			end else if (n_plain < N_PLAIN) begin
				n_plain++;
			end else begin
				bias = (i % 3 != 1);
				relu = (i % 3 != 0);
			end
			w = cmd_word_t'($urandom);  // Unused bits stay random
			w[`GEMM_OP_MSB:`GEMM_OP_LSB]   = op;
			w[`GEMM_RELU_BIT]              = relu;
			w[`GEMM_BIAS_BIT]              = bias;
			w[`GEMM_BLK_MSB:`GEMM_BLK_LSB] = blk;
			w[`GEMM_TAG_MSB:`GEMM_TAG_LSB] = tag;
			cmd_q.push_back(w);
			acc = '0;
			beats_of[i] = 0;
			if (!bad) begin
				if (bias) begin
					b = beat_t'({$urandom, $urandom});
					opd_q.push_back(b);
					for (int l = 0; l < `GEMM_LANES; l++) begin
						acc[l] = acc_t'($signed({b.act[l], b.wt[l]}));
					end
				end
				for (int k = 0; k < int'(blk); k++) begin
					b = beat_t'({$urandom, $urandom});
					opd_q.push_back(b);
					for (int l = 0; l < `GEMM_LANES; l++) begin
						acc[l] = acc[l] + b.act[l] * b.wt[l];  // Wraps at 32 bits
					end
				end
				for (int l = 0; l < `GEMM_LANES; l++) begin
					if (relu && acc[l] < 0) begin
						acc[l] = '0;
					end
				end
				beats_of[i] = int'(blk) + int'(bias);
				exp_res_q.push_back(acc);
			end
			rsp = '0;
			rsp[`GEMM_TAG_MSB:`GEMM_TAG_LSB] = tag;
			rsp[`GEMM_RSP_INV_BIT]           = bad;
			rsp[`GEMM_RSP_CNT_MSB:`GEMM_RSP_CNT_LSB] = bad ? blk_t'(0) : blk_t'(beats_of[i]);
			exp_rsp_q.push_back(rsp);
		end
	endtask

	// FIFO models, sampled on the edge and driven for the next cycle
	always @(posedge axi_aclk) begin
		cmd_word_t rsp_exp;
		acc_vec_t  res_exp;
		int        due;
		if (!rst_n) begin
			cmd_fifo_empty <= 1'b1;
			opd_fifo_empty <= 1'b1;
			rsp_fifo_full  <= 1'b0;
		end else begin
			n_checks++;
			assert (!(cmd_fifo_rd_en && cmd_fifo_empty))
				else report_error("command read while the command FIFO is empty");
			assert (!(opd_fifo_rd_en && opd_fifo_empty))
				else report_error("operand read while the operand FIFO is empty");
			assert (!(rsp_fifo_wr_en && rsp_fifo_full))
				else report_error("response written while the response FIFO is full");
			if (cmd_fifo_rd_en && !cmd_fifo_empty) begin
				void'(cmd_q.pop_front());
				assert (beats_left == 0)
					else report_error("command taken before the beat stream ended");
				beats_left = beats_of[cmd_idx];
				cmd_idx++;
			end
			if (opd_fifo_rd_en && !opd_fifo_empty) begin
				void'(opd_q.pop_front());
				assert (beats_left > 0)
					else report_error("operand read outside a beat stream");
				if (beats_left > 0) begin
					beats_left--;
					if (beats_left == 0) begin
						exp_cyc_q.push_back(cyc + 3);  // Result due 3 cycles later
					end
				end
			end
			if (rsp_fifo_wr_en && !rsp_fifo_full) begin
				rsp_seen++;
				assert (exp_rsp_q.size() > 0) else report_error("response with none expected");
				if (exp_rsp_q.size() > 0) begin
					rsp_exp = exp_rsp_q.pop_front();
					check_value("xocc_rsp_out", xocc_rsp_out, rsp_exp);
				end
			end
			if (result_valid) begin
				assert (exp_res_q.size() > 0 && exp_cyc_q.size() > 0)
					else report_error("result_valid with no result expected");
				if (exp_res_q.size() > 0 && exp_cyc_q.size() > 0) begin
					res_exp = exp_res_q.pop_front();
					due     = exp_cyc_q.pop_front();
					check_value("result_data", result_data, res_exp);
					check_value("result_valid cycle", cyc, due);
				end
			end
			cmd_fifo_empty <= (cmd_q.size() == 0) || ($urandom_range(3) == 0);
			xocc_cmd_in    <= (cmd_q.size() > 0) ? cmd_q[0] : cmd_word_t'($urandom);
			opd_fifo_empty <= (opd_q.size() == 0) || ($urandom_range(3) == 0);
			opd_in         <= (opd_q.size() > 0) ? opd_q[0] : beat_t'({$urandom, $urandom});
			rsp_fifo_full  <= ($urandom_range(2) == 0);
		end
		cyc = cyc + 1;
	end

	initial begin
		rst_n          = 1'b0;
		cmd_fifo_empty = 1'b1;
		xocc_cmd_in    = '0;
		opd_fifo_empty = 1'b1;
		opd_in         = '0;
		rsp_fifo_full  = 1'b0;
		cyc            = 0;
		cmd_idx        = 0;
		beats_left     = 0;
		rsp_seen       = 0;
		n_checks       = 0;
		n_errors       = 0;
		void'($urandom(97958));
		build_stimulus();
		repeat (4) @(posedge axi_aclk);
		rst_n <= 1'b1;
		while (rsp_seen < N_CMD) begin
			@(posedge axi_aclk);
		end
		repeat (8) @(posedge axi_aclk);
		n_checks++;
		assert (exp_res_q.size() == 0 && opd_q.size() == 0 && cmd_q.size() == 0)
			else report_error("expected traffic left over at the end of the run");
		end_run();
	end

	// Watchdog
	initial begin
		repeat (LIMIT) @(posedge axi_aclk);
		report_error($sformatf("timeout after %0d cycles with %0d of %0d responses",
			LIMIT, rsp_seen, N_CMD));
		end_run();
	end

endmodule

/* verilog/gemm_core_top.sv */
// GEMM dot-product core top
`timescale 1ns/1ps

module gemm_core_top (
	input  logic                axi_aclk,
	input  logic                rst_n,

	// Command FIFO, first-word-fall-through
	input  logic                cmd_fifo_empty,
	input  gemm_pkg::cmd_word_t xocc_cmd_in,
	output logic                cmd_fifo_rd_en,

	// Operand FIFO, first-word-fall-through
	input  logic                opd_fifo_empty,
	input  gemm_pkg::beat_t     opd_in,
	output logic                opd_fifo_rd_en,

	// Response FIFO
	input  logic                rsp_fifo_full,
	output logic                rsp_fifo_wr_en,
	output gemm_pkg::cmd_word_t xocc_rsp_out,

	// Result vector
	output logic                result_valid,
	output gemm_pkg::acc_vec_t  result_data
);
	import gemm_pkg::*;

	beat_t    mac_beat;
	mac_ctl_t mac_ctl;
	acc_vec_t acc_vec;
	logic     acc_done;
	logic     acc_relu;

	cmd_decode u_cmd_decode (
		.axi_aclk       (axi_aclk),
		.rst_n          (rst_n),
		.cmd_fifo_empty (cmd_fifo_empty),
		.xocc_cmd_in    (xocc_cmd_in),
		.opd_fifo_empty (opd_fifo_empty),
		.opd_in         (opd_in),
		.rsp_fifo_full  (rsp_fifo_full),
		.gemm_done      (result_valid),  // Result leaving the core ends the command
		.cmd_fifo_rd_en (cmd_fifo_rd_en),
		.opd_fifo_rd_en (opd_fifo_rd_en),
		.rsp_fifo_wr_en (rsp_fifo_wr_en),
		.xocc_rsp_out   (xocc_rsp_out),
		.mac_beat       (mac_beat),
		.mac_ctl        (mac_ctl)
	);

	mac_lanes u_mac_lanes (
		.axi_aclk (axi_aclk),
		.rst_n    (rst_n),
		.mac_beat (mac_beat),
		.mac_ctl  (mac_ctl),
		.acc_vec  (acc_vec),
		.acc_done (acc_done),
		.acc_relu (acc_relu)
	);

	result_stage u_result_stage (
		.axi_aclk     (axi_aclk),
		.rst_n        (rst_n),
		.acc_vec      (acc_vec),
		.acc_done     (acc_done),
		.acc_relu     (acc_relu),
		.result_valid (result_valid),
		.result_data  (result_data)
	);

endmodule

/* verilog/result_stage.sv */
// ReLU and result register
`timescale 1ns/1ps
`include "gemm_defs.svh"

module result_stage (
	input  logic               axi_aclk,
	input  logic               rst_n,
	input  gemm_pkg::acc_vec_t acc_vec,
	input  logic               acc_done,
	input  logic               acc_relu,
	output logic               result_valid,
	output gemm_pkg::acc_vec_t result_data
);
	import gemm_pkg::*;

	acc_vec_t relu_vec;

	// Negative lanes go to zero only when ReLU is requested
	always_comb begin
		for (int i = 0; i < `GEMM_LANES; i++) begin
			if (acc_relu && acc_vec[i][`GEMM_ACC_W-1]) begin
				relu_vec[i] = '0;
			end else begin
				relu_vec[i] = acc_vec[i];
			end
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= acc_done;  // One-cycle pulse
		end
	end

	// Data holds until the next block finishes
	always_ff @(posedge axi_aclk) begin
		if (acc_done) begin
			result_data <= relu_vec;
		end
	end

endmodule

/* verilog/mac_lanes.sv */
// Four-lane INT8 multiply-accumulate
`timescale 1ns/1ps
`include "gemm_defs.svh"

module mac_lanes (
	input  logic               axi_aclk,
	input  logic               rst_n,
	input  gemm_pkg::beat_t    mac_beat,
	input  gemm_pkg::mac_ctl_t mac_ctl,
	output gemm_pkg::acc_vec_t acc_vec,
	output logic               acc_done,
	output logic               acc_relu
);
	import gemm_pkg::*;

	// Products and bias values are both 16 bits wide
	logic signed [2*`GEMM_OPD_W-1:0] term_nxt [`GEMM_LANES];
	logic signed [2*`GEMM_OPD_W-1:0] s1_term  [`GEMM_LANES];

	logic s1_valid;
	logic s1_load;   // Overwrite instead of add
	logic s1_last;
	logic s1_relu;
	logic first_q;   // Next beat opens a new block

	always_comb begin
		for (int i = 0; i < `GEMM_LANES; i++) begin
			if (mac_ctl.is_bias) begin
				term_nxt[i] = {mac_beat.act[i], mac_beat.wt[i]};  // act is the high byte
			end else begin
				term_nxt[i] = mac_beat.act[i] * mac_beat.wt[i];
			end
		end
	end

	// Stage one control
	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_load  <= 1'b0;
			s1_last  <= 1'b0;
			s1_relu  <= 1'b0;
			first_q  <= 1'b1;
		end else begin
			s1_valid <= mac_ctl.valid;
			if (mac_ctl.valid) begin
				s1_load <= mac_ctl.is_bias || first_q;
				s1_last <= mac_ctl.last;
				s1_relu <= mac_ctl.relu;
				first_q <= mac_ctl.last;  // Bias beat clears it too
			end
		end
	end

	// Stage one terms
	always_ff @(posedge axi_aclk) begin
		if (mac_ctl.valid) begin
			for (int i = 0; i < `GEMM_LANES; i++) begin
				s1_term[i] <= term_nxt[i];
			end
		end
	end

	// Stage two accumulate, modulo 2^32
	always_ff @(posedge axi_aclk) begin
		if (s1_valid) begin
			for (int i = 0; i < `GEMM_LANES; i++) begin
				if (s1_load) begin
					acc_vec[i] <= acc_t'(s1_term[i]);
				end else begin
					acc_vec[i] <= acc_vec[i] + acc_t'(s1_term[i]);
				end
			end
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			acc_done <= 1'b0;
			acc_relu <= 1'b0;
		end else begin
			acc_done <= s1_valid && s1_last;  // Single cycle per block
			if (s1_valid) begin
				acc_relu <= s1_relu;
			end
		end
	end

endmodule

/* verilog/cmd_decode.sv */
// Command decoder and FIFO control
`timescale 1ns/1ps
`include "gemm_defs.svh"

module cmd_decode (
	input  logic                axi_aclk,
	input  logic                rst_n,
	input  logic                cmd_fifo_empty,
	input  gemm_pkg::cmd_word_t xocc_cmd_in,
	input  logic                opd_fifo_empty,
	input  gemm_pkg::beat_t     opd_in,
	input  logic                rsp_fifo_full,
	input  logic                gemm_done,
	output logic                cmd_fifo_rd_en,
	output logic                opd_fifo_rd_en,
	output logic                rsp_fifo_wr_en,
	output gemm_pkg::cmd_word_t xocc_rsp_out,
	output gemm_pkg::beat_t     mac_beat,
	output gemm_pkg::mac_ctl_t  mac_ctl
);
	import gemm_pkg::*;

	dec_state_t state;
	dec_state_t state_nxt;

	tag_t  tag_q;
	blk_t  rem_q;   // Beats left in RUN
	blk_t  cnt_q;   // Beats consumed, bias included
	logic  relu_q;
	logic  inv_q;

	logic [`GEMM_OP_W-1:0] cmd_op;
	blk_t                  cmd_blk;
	tag_t                  cmd_tag;
	logic                  cmd_bias;
	logic                  cmd_relu;
	logic                  cmd_bad;
	logic                  opd_take;
	logic                  last_beat;

	// The FWFT head word is decoded in the cycle it is popped
	assign cmd_op   = xocc_cmd_in[`GEMM_OP_MSB:`GEMM_OP_LSB];
	assign cmd_blk  = xocc_cmd_in[`GEMM_BLK_MSB:`GEMM_BLK_LSB];
	assign cmd_tag  = xocc_cmd_in[`GEMM_TAG_MSB:`GEMM_TAG_LSB];
	assign cmd_bias = xocc_cmd_in[`GEMM_BIAS_BIT];
	assign cmd_relu = xocc_cmd_in[`GEMM_RELU_BIT];
	assign cmd_bad  = (cmd_op != `GEMM_OP_MAC) || (cmd_blk == '0);

	// FIFO strobes
	assign cmd_fifo_rd_en = (state == IDLE) && !cmd_fifo_empty;
	assign opd_take       = ((state == BIAS) || (state == RUN)) && !opd_fifo_empty;
	assign opd_fifo_rd_en = opd_take;
	assign rsp_fifo_wr_en = (state == RESPOND) && !rsp_fifo_full;

	assign last_beat = opd_take && (state == RUN) && (rem_q == blk_t'(1));

	// Beat goes to the lanes in the same cycle it leaves the FIFO
	assign mac_beat = opd_in;

	always_comb begin
		mac_ctl.valid   = opd_take;
		mac_ctl.is_bias = opd_take && (state == BIAS);
		mac_ctl.last    = last_beat;
		mac_ctl.relu    = relu_q;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (cmd_fifo_rd_en) begin
					if (cmd_bad) begin
						state_nxt = RESPOND;  // No operands for a bad command
					end else if (cmd_bias) begin
						state_nxt = BIAS;
					end else begin
						state_nxt = RUN;
					end
				end
			end
			BIAS: begin
				if (opd_take) begin
					state_nxt = RUN;
				end
			end
			RUN: begin
				if (last_beat) begin
					state_nxt = WAIT_DONE;
				end
			end
			WAIT_DONE: begin
				if (gemm_done) begin
					state_nxt = RESPOND;  // Result left the pipe
				end
			end
			RESPOND: begin
				if (rsp_fifo_wr_en) begin
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Per-command control
	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			rem_q  <= '0;
			cnt_q  <= '0;
			relu_q <= 1'b0;
			inv_q  <= 1'b0;
		end else if (cmd_fifo_rd_en) begin
			rem_q  <= cmd_blk;
			cnt_q  <= '0;
			relu_q <= cmd_relu;
			inv_q  <= cmd_bad;
		end else if (opd_take) begin
			cnt_q <= cnt_q + blk_t'(1);  // Wraps at 64 with bias on a full block
			if (state == RUN) begin
				rem_q <= rem_q - blk_t'(1);
			end
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (cmd_fifo_rd_en) begin
			tag_q <= cmd_tag;
		end
	end

	// Response word
	always_comb begin
		xocc_rsp_out = '0;
		xocc_rsp_out[`GEMM_TAG_MSB:`GEMM_TAG_LSB]         = tag_q;
		xocc_rsp_out[`GEMM_RSP_INV_BIT]                   = inv_q;
		xocc_rsp_out[`GEMM_RSP_CNT_MSB:`GEMM_RSP_CNT_LSB] = cnt_q;
	end

endmodule

/* verilog/gemm_pkg.sv */
// GEMM core types
`include "gemm_defs.svh"

package gemm_pkg;

	// Plain vectors
	typedef logic        [`GEMM_CMD_W-1:0] cmd_word_t;  // Command or response word
	typedef logic signed [`GEMM_OPD_W-1:0] opd_t;       // INT8 operand
	typedef logic signed [`GEMM_ACC_W-1:0] acc_t;       // Lane accumulator
	typedef logic        [`GEMM_BLK_W-1:0] blk_t;       // Block size or beat count
	typedef logic        [`GEMM_TAG_W-1:0] tag_t;       // Command tag

	// One operand FIFO word, lane 0 in the low byte of each half
	typedef struct packed {
		opd_t [`GEMM_LANES-1:0] act;
		opd_t [`GEMM_LANES-1:0] wt;
	} beat_t;

	typedef acc_t [`GEMM_LANES-1:0] acc_vec_t;

	// Sideband that travels with every beat into the MAC pipe
	typedef struct packed {
		logic valid;    // Beat consumed this cycle
		logic is_bias;  // Preload beat
		logic last;     // Final beat of the block
		logic relu;     // Clamp the result
	} mac_ctl_t;

	typedef enum logic [2:0] {
		IDLE,
		BIAS,
		RUN,
		WAIT_DONE,
		RESPOND
	} dec_state_t;

endpackage

/* verilog/gemm_defs.svh */
// GEMM core constants
`ifndef GEMM_DEFS_SVH
`define GEMM_DEFS_SVH

// Datapath sizes
`define GEMM_LANES   4
`define GEMM_OPD_W   8
`define GEMM_ACC_W   32
`define GEMM_CMD_W   32
`define GEMM_BLK_W   6
`define GEMM_TAG_W   16

// Opcode
`define GEMM_OP_W    4
`define GEMM_OP_MAC  4'd1

// Command word fields
`define GEMM_OP_LSB    0
`define GEMM_OP_MSB    3
`define GEMM_RELU_BIT  4
`define GEMM_BIAS_BIT  5
`define GEMM_BLK_LSB   6
`define GEMM_BLK_MSB   11
`define GEMM_TAG_LSB   16
`define GEMM_TAG_MSB   31

// Response word fields, tag shares the command position
`define GEMM_RSP_INV_BIT  8
`define GEMM_RSP_CNT_LSB  0
`define GEMM_RSP_CNT_MSB  5

`endif
